//--- source/lsu_pkg.sv
// shared widths and encodings for the load/store stage; accesses must be naturally aligned
package lsu_pkg;

  // datapath widths
  localparam int DATA_W = 64;
  localparam int ADDR_W = 32;
  localparam int MASK_W = DATA_W / 8;

  typedef logic [DATA_W-1:0] data_t; // one doubleword
  typedef logic [ADDR_W-1:0] addr_t; // byte address
  typedef logic [MASK_W-1:0] mask_t; // one enable per byte lane

  // operation of a pipeline request
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  // access size, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    SZ_BYTE   = 2'd0,
    SZ_HALF   = 2'd1,
    SZ_WORD   = 2'd2,
    SZ_DOUBLE = 2'd3
  } mem_size_e;

endpackage

//--- source/lsu_load_extend.sv
// combinational lane select and extension; offset must be aligned to size
`timescale 1ns/10ps

module lsu_load_extend (
  input  lsu_pkg::data_t     word_i,
  input  logic [2:0]         offset_i,
  input  lsu_pkg::mem_size_e size_i,
  input  logic               sext_i,
  output lsu_pkg::data_t     value_o
);

  localparam int W = lsu_pkg::DATA_W;

  lsu_pkg::data_t lane;
  logic           fill;

  // addressed byte moved down to bit 0
  assign lane = word_i >> {offset_i, 3'b000};

  always_comb begin
    case (size_i)
      lsu_pkg::SZ_BYTE: begin
        fill    = sext_i & lane[7];
        value_o = {{(W-8){fill}}, lane[7:0]};
      end
      lsu_pkg::SZ_HALF: begin
        fill    = sext_i & lane[15];
        value_o = {{(W-16){fill}}, lane[15:0]};
      end
      lsu_pkg::SZ_WORD: begin
        fill    = sext_i & lane[31];
        value_o = {{(W-32){fill}}, lane[31:0]};
      end
      default: begin
        fill    = 1'b0; // full width, nothing to extend
        value_o = lane;
      end
    endcase
  end

endmodule

//--- source/lsu_req_capture.sv
// one-entry request register; ready is combinational from cap_ready_i, payload is not reset
`timescale 1ns/10ps

module lsu_req_capture (
  input  logic                clk,
  input  logic                rst_n_i,
  // pipeline side
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  lsu_pkg::mem_op_e    req_op_i,
  input  lsu_pkg::addr_t      req_addr_i,
  input  lsu_pkg::data_t      req_wdata_i,
  input  lsu_pkg::mem_size_e  req_size_i,
  input  logic                req_sext_i,
  // control side
  output logic                cap_valid_o,
  input  logic                cap_ready_i,
  output lsu_pkg::mem_op_e    cap_op_o,
  output lsu_pkg::addr_t      cap_addr_o,
  output lsu_pkg::data_t      cap_wdata_o,
  output lsu_pkg::mem_size_e  cap_size_o,
  output logic                cap_sext_o
);

  logic               valid_q;
  lsu_pkg::mem_op_e   op_q;
  lsu_pkg::addr_t     addr_q;
  lsu_pkg::data_t     wdata_q;
  lsu_pkg::mem_size_e size_q;
  logic               sext_q;
  logic               load_en;

  // room when empty or when the held entry leaves this cycle
  assign req_ready_o = ~valid_q | cap_ready_i;
  assign load_en     = req_valid_i & req_ready_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i; // refill or go empty
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      op_q    <= req_op_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      size_q  <= req_size_i;
      sext_q  <= req_sext_i;
    end
  end

  assign cap_valid_o = valid_q;
  assign cap_op_o    = op_q;
  assign cap_addr_o  = addr_q;
  assign cap_wdata_o = wdata_q;
  assign cap_size_o  = size_q;
  assign cap_sext_o  = sext_q;

endmodule

//--- source/lsu_access_ctrl.sv
// serial access FSM, one access at a time; stores give no response, requests must be aligned
`timescale 1ns/10ps

module lsu_access_ctrl (
  input  logic               clk,
  input  logic               rst_n_i,
  // from the capture register
  input  logic               cap_valid_i,
  output logic               cap_ready_o,
  input  lsu_pkg::mem_op_e   cap_op_i,
  input  lsu_pkg::addr_t     cap_addr_i,
  input  lsu_pkg::data_t     cap_wdata_i,
  input  lsu_pkg::mem_size_e cap_size_i,
  input  logic               cap_sext_i,
  // write channel and acknowledge
  output logic               w_valid_o,
  input  logic               w_ready_i,
  output lsu_pkg::addr_t     w_addr_o,
  output lsu_pkg::data_t     w_data_o,
  output lsu_pkg::mask_t     w_mask_o,
  input  logic               b_valid_i,
  output logic               b_ready_o,
  // read request and data
  output logic               ar_valid_o,
  input  logic               ar_ready_i,
  output lsu_pkg::addr_t     ar_addr_o,
  input  logic               r_valid_i,
  output logic               r_ready_o,
  input  lsu_pkg::data_t     r_data_i,
  // load response
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output lsu_pkg::data_t     resp_rdata_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ST_ISSUE,
    S_ST_ACK,
    S_LD_ISSUE,
    S_LD_DATA,
    S_RESPOND
  } state_e;

  state_e             state_q, state_d;
  lsu_pkg::addr_t     addr_q;
  lsu_pkg::data_t     data_q;
  lsu_pkg::mask_t     mask_q;
  lsu_pkg::mem_size_e size_q;
  logic               sext_q;
  lsu_pkg::data_t     rdata_q;
  lsu_pkg::data_t     st_data;
  lsu_pkg::mask_t     st_mask;
  lsu_pkg::data_t     ext_value;
  logic               cap_hs;

  assign cap_ready_o = (state_q == S_IDLE);
  assign cap_hs      = cap_valid_i & cap_ready_o;

  // store data replicated over every lane, mask picks the addressed one
  always_comb begin
    case (cap_size_i)
      lsu_pkg::SZ_BYTE: begin
        st_data = {8{cap_wdata_i[7:0]}};
        st_mask = 8'h01;
      end
      lsu_pkg::SZ_HALF: begin
        st_data = {4{cap_wdata_i[15:0]}};
        st_mask = 8'h03;
      end
      lsu_pkg::SZ_WORD: begin
        st_data = {2{cap_wdata_i[31:0]}};
        st_mask = 8'h0f;
      end
      default: begin
        st_data = cap_wdata_i;
        st_mask = 8'hff;
      end
    endcase
    st_mask = st_mask << cap_addr_i[2:0];
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: if (cap_hs) begin
        state_d = (cap_op_i == lsu_pkg::OP_STORE) ? S_ST_ISSUE : S_LD_ISSUE;
      end
      S_ST_ISSUE: if (w_ready_i) state_d = S_ST_ACK;
      S_ST_ACK:   if (b_valid_i) state_d = S_IDLE; // store done
      S_LD_ISSUE: if (ar_ready_i) state_d = S_LD_DATA;
      S_LD_DATA:  if (r_valid_i) state_d = S_RESPOND;
      S_RESPOND:  if (resp_ready_i) state_d = S_IDLE;
      default:    state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (cap_hs) begin
      addr_q <= cap_addr_i;
      data_q <= st_data;
      mask_q <= st_mask;
      size_q <= cap_size_i;
      sext_q <= cap_sext_i;
    end
    if (r_valid_i && r_ready_o) begin
      rdata_q <= ext_value; // held until the response is taken
    end
  end

  lsu_load_extend u_load_extend (
    .word_i   (r_data_i),
    .offset_i (addr_q[2:0]),
    .size_i   (size_q),
    .sext_i   (sext_q),
    .value_o  (ext_value)
  );

  assign w_valid_o    = (state_q == S_ST_ISSUE);
  assign w_addr_o     = addr_q;
  assign w_data_o     = data_q;
  assign w_mask_o     = mask_q;
  assign b_ready_o    = (state_q == S_ST_ACK);
  assign ar_valid_o   = (state_q == S_LD_ISSUE);
  assign ar_addr_o    = addr_q;
  assign r_ready_o    = (state_q == S_LD_DATA);
  assign resp_valid_o = (state_q == S_RESPOND);
  assign resp_rdata_o = rdata_q;

endmodule

//--- source/lsu_bus_sram.sv
// bus-slave doubleword memory, one transaction at a time, contents not reset; RD_LAT >= 1
`timescale 1ns/10ps

module lsu_bus_sram #(
  parameter int MEM_WORDS_LOG2 = 8,
  parameter int RD_LAT         = 2
) (
  input  logic           clk,
  input  logic           rst_n_i,
  // write channel
  input  logic           w_valid_i,
  output logic           w_ready_o,
  input  lsu_pkg::addr_t w_addr_i,
  input  lsu_pkg::data_t w_data_i,
  input  lsu_pkg::mask_t w_mask_i,
  output logic           b_valid_o,
  input  logic           b_ready_i,
  // read channels
  input  logic           ar_valid_i,
  output logic           ar_ready_o,
  input  lsu_pkg::addr_t ar_addr_i,
  output logic           r_valid_o,
  input  logic           r_ready_i,
  output lsu_pkg::data_t r_data_o
);

  localparam int DEPTH = 2 ** MEM_WORDS_LOG2;
  localparam int CNT_W = $clog2(RD_LAT + 1);

  lsu_pkg::data_t            mem [DEPTH];
  logic [MEM_WORDS_LOG2-1:0] w_idx;
  logic [MEM_WORDS_LOG2-1:0] ar_idx;
  logic [MEM_WORDS_LOG2-1:0] rd_idx_q;
  logic [MEM_WORDS_LOG2-1:0] rd_idx;
  logic                      b_valid_q;
  logic                      r_valid_q;
  logic                      rd_pend_q;
  logic [CNT_W-1:0]          cnt_q;
  lsu_pkg::data_t            r_data_q;
  logic                      busy;
  logic                      w_hs;
  logic                      ar_hs;
  logic                      fire;

  // doubleword index from the byte address
  assign w_idx  = w_addr_i[MEM_WORDS_LOG2+2:3];
  assign ar_idx = ar_addr_i[MEM_WORDS_LOG2+2:3];

  assign busy       = b_valid_q | rd_pend_q;
  assign w_ready_o  = ~busy;
  assign ar_ready_o = ~busy & ~w_valid_i; // write wins a tie
  assign w_hs       = w_valid_i & w_ready_o;
  assign ar_hs      = ar_valid_i & ar_ready_o;

  // read data due at this edge
  assign fire   = (ar_hs && RD_LAT == 1) ||
                  (rd_pend_q && !r_valid_q && cnt_q == CNT_W'(1));
  assign rd_idx = ar_hs ? ar_idx : rd_idx_q;

  always_ff @(posedge clk) begin
    if (w_hs) begin
      for (int i = 0; i < lsu_pkg::MASK_W; i++) begin
        if (w_mask_i[i]) mem[w_idx][8*i +: 8] <= w_data_i[8*i +: 8];
      end
    end
    if (ar_hs) rd_idx_q <= ar_idx;
    if (fire) r_data_q <= mem[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
      rd_pend_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      if (w_hs) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (ar_hs) begin
        rd_pend_q <= 1'b1;
        cnt_q     <= CNT_W'(RD_LAT - 1);
      end else if (rd_pend_q && !r_valid_q && !fire) begin
        cnt_q <= cnt_q - 1'b1; // latency countdown
      end
      if (fire) begin
        r_valid_q <= 1'b1;
      end else if (r_valid_q && r_ready_i) begin
        r_valid_q <= 1'b0;
        rd_pend_q <= 1'b0;
      end
    end
  end

  assign b_valid_o = b_valid_q;
  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

endmodule

//--- source/lsu_mem_top.sv
// load/store stage with its own memory; aligned accesses only, only loads return a response
`timescale 1ns/10ps

module lsu_mem_top #(
  parameter int MEM_WORDS_LOG2 = 8,
  parameter int RD_LAT         = 2
) (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  lsu_pkg::mem_op_e   req_op_i,
  input  lsu_pkg::addr_t     req_addr_i,
  input  lsu_pkg::data_t     req_wdata_i,
  input  lsu_pkg::mem_size_e req_size_i,
  input  logic               req_sext_i,
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output lsu_pkg::data_t     resp_rdata_o
);

  logic               cap_valid, cap_ready;
  lsu_pkg::mem_op_e   cap_op;
  lsu_pkg::addr_t     cap_addr;
  lsu_pkg::data_t     cap_wdata;
  lsu_pkg::mem_size_e cap_size;
  logic               cap_sext;
  // bus between control and memory
  logic               w_valid, w_ready, b_valid, b_ready;
  lsu_pkg::addr_t     w_addr, ar_addr;
  lsu_pkg::data_t     w_data, r_data;
  lsu_pkg::mask_t     w_mask;
  logic               ar_valid, ar_ready, r_valid, r_ready;

  lsu_req_capture u_req_capture (
    .clk (clk), .rst_n_i (rst_n_i),
    .req_valid_i (req_valid_i), .req_ready_o (req_ready_o),
    .req_op_i (req_op_i), .req_addr_i (req_addr_i), .req_wdata_i (req_wdata_i),
    .req_size_i (req_size_i), .req_sext_i (req_sext_i),
    .cap_valid_o (cap_valid), .cap_ready_i (cap_ready),
    .cap_op_o (cap_op), .cap_addr_o (cap_addr), .cap_wdata_o (cap_wdata),
    .cap_size_o (cap_size), .cap_sext_o (cap_sext)
  );

  lsu_access_ctrl u_access_ctrl (
    .clk (clk), .rst_n_i (rst_n_i),
    .cap_valid_i (cap_valid), .cap_ready_o (cap_ready),
    .cap_op_i (cap_op), .cap_addr_i (cap_addr), .cap_wdata_i (cap_wdata),
    .cap_size_i (cap_size), .cap_sext_i (cap_sext),
    .w_valid_o (w_valid), .w_ready_i (w_ready), .w_addr_o (w_addr),
    .w_data_o (w_data), .w_mask_o (w_mask),
    .b_valid_i (b_valid), .b_ready_o (b_ready),
    .ar_valid_o (ar_valid), .ar_ready_i (ar_ready), .ar_addr_o (ar_addr),
    .r_valid_i (r_valid), .r_ready_o (r_ready), .r_data_i (r_data),
    .resp_valid_o (resp_valid_o), .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o)
  );

  lsu_bus_sram #(
    .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
    .RD_LAT         (RD_LAT)
  ) u_bus_sram (
    .clk (clk), .rst_n_i (rst_n_i),
    .w_valid_i (w_valid), .w_ready_o (w_ready), .w_addr_i (w_addr),
    .w_data_i (w_data), .w_mask_i (w_mask),
    .b_valid_o (b_valid), .b_ready_i (b_ready),
    .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_addr_i (ar_addr),
    .r_valid_o (r_valid), .r_ready_i (r_ready), .r_data_o (r_data)
  );

endmodule

//--- bench/lsu_mem_clkgen.sv
// free-running 10 ns clock; reset low for RESET_CYCLES edges, released on a falling edge
`timescale 1ns/10ps

module lsu_mem_clkgen #(
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n_o
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // half period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_o = 1'b1;
  end

endmodule

//--- bench/lsu_mem_props.sv
// bound into lsu_mem_top; the alignment check assumes req_size_i is a legal size encoding
`timescale 1ns/10ps

module lsu_mem_props (
  input logic               clk,
  input logic               rst_n_i,
  input logic               req_valid_i,
  input logic               req_ready_i,
  input lsu_pkg::addr_t     req_addr_i,
  input lsu_pkg::mem_size_e req_size_i,
  input logic               resp_valid_i,
  input logic               resp_ready_i,
  input lsu_pkg::data_t     resp_rdata_i,
  input logic               w_valid_i,
  input logic               w_ready_i,
  input logic               ar_valid_i,
  input logic               ar_ready_i,
  input logic               b_valid_i,
  input logic               r_valid_i
);

  logic [2:0] align_mask;

  assign align_mask = (3'd1 << req_size_i) - 3'd1; // low address bits that must be zero

  resp_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_rdata_i))
    else $error("load response dropped or changed before acceptance");

  w_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    w_valid_i && !w_ready_i |=> w_valid_i)
    else $error("w_valid dropped before its handshake");

  ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    ar_valid_i && !ar_ready_i |=> ar_valid_i)
    else $error("ar_valid dropped before its handshake");

  aligned_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_valid_i && req_ready_i |-> (req_addr_i[2:0] & align_mask) == 3'd0)
    else $error("accepted request is not naturally aligned");

  // first sampled edge out of reset
  reset_quiet_a: assert property (@(posedge clk)
    $rose(rst_n_i) |-> !(resp_valid_i | w_valid_i | ar_valid_i | b_valid_i | r_valid_i))
    else $error("control outputs high right after reset release");

endmodule

bind lsu_mem_top lsu_mem_props u_props (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .req_valid_i  (req_valid_i),
  .req_ready_i  (req_ready_o),
  .req_addr_i   (req_addr_i),
  .req_size_i   (req_size_i),
  .resp_valid_i (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_rdata_i (resp_rdata_o),
  .w_valid_i    (w_valid),
  .w_ready_i    (w_ready),
  .ar_valid_i   (ar_valid),
  .ar_ready_i   (ar_ready),
  .b_valid_i    (b_valid),
  .r_valid_i    (r_valid)
);

//--- bench/lsu_mem_tb.sv
// directed tests against a byte-array model; only written bytes are ever loaded back
`timescale 1ns/10ps

module lsu_mem_tb;

  localparam int MEM_WORDS_LOG2 = 8;
  localparam int RD_LAT         = 2;
  localparam int RESET_CYCLES   = 10;
  localparam int BYTE_AW        = MEM_WORDS_LOG2 + 3;
  localparam int N_RANDOM       = 120;
  localparam int N_ACCESSES     = 2 + 5 + 31 + 8 + N_RANDOM;
  localparam int ACCESS_BOUND   = RD_LAT + 8 + 4 * 8; // issue, latency, stall stretches
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 + N_ACCESSES * ACCESS_BOUND;
  localparam lsu_pkg::addr_t RAND_BASE = 32'h100;

  logic               clk, rst_n;
  logic               req_valid, req_ready, req_sext;
  lsu_pkg::mem_op_e   req_op;
  lsu_pkg::addr_t     req_addr;
  lsu_pkg::data_t     req_wdata;
  lsu_pkg::mem_size_e req_size;
  logic               resp_valid, resp_ready;
  lsu_pkg::data_t     resp_rdata;

  logic [7:0]         ref_mem [2**BYTE_AW];
  lsu_pkg::data_t     exp_q [$]; // expected load results in issue order
  int                 errors = 0;
  int                 checks = 0;
  int                 tests = 0;
  int                 cycles = 0;
  int                 stall_left = 0;
  logic               stall_en = 1'b0;
  integer             stim_seed = 32'h6aac596b;
  integer             stall_seed = 32'h6aac596b;

  lsu_mem_clkgen #(.RESET_CYCLES (RESET_CYCLES)) u_clkgen (.clk (clk), .rst_n_o (rst_n));

  lsu_mem_top #(
    .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
    .RD_LAT         (RD_LAT)
  ) dut0 (
    .clk (clk), .rst_n_i (rst_n),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_op_i (req_op),
    .req_addr_i (req_addr), .req_wdata_i (req_wdata), .req_size_i (req_size),
    .req_sext_i (req_sext),
    .resp_valid_o (resp_valid), .resp_ready_i (resp_ready), .resp_rdata_o (resp_rdata)
  );

  task automatic compare_data(input lsu_pkg::data_t got, input lsu_pkg::data_t exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic model_store(input lsu_pkg::addr_t a, input lsu_pkg::data_t d,
                             input lsu_pkg::mem_size_e s);
    for (int i = 0; i < (1 << int'(s)); i++) begin
      ref_mem[a[BYTE_AW-1:0] + BYTE_AW'(i)] = d[8*i +: 8];
    end
  endtask

  function automatic lsu_pkg::data_t model_load(input lsu_pkg::addr_t a,
                                                input lsu_pkg::mem_size_e s, input logic sext);
    lsu_pkg::data_t v;
    int n;
    n = 1 << int'(s);
    v = '0;
    for (int i = 0; i < n; i++) v[8*i +: 8] = ref_mem[a[BYTE_AW-1:0] + BYTE_AW'(i)];
    if (sext && v[8*n-1]) begin
      for (int i = 8 * n; i < lsu_pkg::DATA_W; i++) v[i] = 1'b1; // sign fill
    end
    return v;
  endfunction

  // holds the request until accepted, then updates the model
  task automatic send_req(input lsu_pkg::mem_op_e op, input lsu_pkg::addr_t addr,
                          input lsu_pkg::data_t wdata, input lsu_pkg::mem_size_e size,
                          input logic sext);
    @(negedge clk);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = wdata;
    req_size  = size;
    req_sext  = sext;
    while (!req_ready) @(negedge clk);
    if (op == lsu_pkg::OP_STORE) model_store(addr, wdata, size);
    else exp_q.push_back(model_load(addr, size, sext));
    @(posedge clk);
  endtask

  task automatic drain_responses();
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk); // a late extra response shows up here
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests++;
    $display("test %-14s errors %0d", name, errors - errs_at_start);
  endtask

  // ready is decided before the handshake is judged
  always @(negedge clk) begin
    if (rst_n) begin
      if (stall_en && stall_left > 0) begin
        resp_ready = 1'b0;
        stall_left--;
      end else if (stall_en && ($random(stall_seed) & 3) == 0) begin
        resp_ready = 1'b0;
        stall_left = $random(stall_seed) & 7;
      end else begin
        resp_ready = 1'b1;
      end
      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("error at %0t: load response arrived with no load outstanding", $time);
        end else begin
          compare_data(resp_rdata, exp_q.pop_front(), "load data");
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("error: timeout, the DUT made no progress within %0d cycles", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    @(negedge clk);
    compare_bit(resp_valid, 1'b0, "resp_valid after reset");
    compare_bit(req_ready, 1'b1, "req_ready after reset");
    report_test("reset_state", e0);
  endtask

  task automatic test_double_rw();
    int e0;
    e0 = errors;
    send_req(lsu_pkg::OP_STORE, 32'h40, 64'h0123_4567_89ab_cdef, lsu_pkg::SZ_DOUBLE, 1'b0);
    send_req(lsu_pkg::OP_LOAD, 32'h40, '0, lsu_pkg::SZ_DOUBLE, 1'b0);
    drain_responses();
    report_test("double_rw", e0);
  endtask

  task automatic test_lane_merge();
    int e0;
    e0 = errors;
    send_req(lsu_pkg::OP_STORE, 32'h80, 64'hffff_ffff_ffff_ffff, lsu_pkg::SZ_DOUBLE, 1'b0);
    send_req(lsu_pkg::OP_STORE, 32'h81, 64'h0000_0000_0000_00a5, lsu_pkg::SZ_BYTE, 1'b0);
    send_req(lsu_pkg::OP_STORE, 32'h82, 64'h0000_0000_0000_3c96, lsu_pkg::SZ_HALF, 1'b0);
    send_req(lsu_pkg::OP_STORE, 32'h84, 64'h0000_0000_1234_5678, lsu_pkg::SZ_WORD, 1'b0);
    send_req(lsu_pkg::OP_LOAD, 32'h80, '0, lsu_pkg::SZ_DOUBLE, 1'b0);
    drain_responses();
    report_test("lane_merge", e0);
  endtask

  task automatic test_load_extend();
    int e0;
    e0 = errors;
    send_req(lsu_pkg::OP_STORE, 32'hc0, 64'h8070_f0e1_7f82_a3c4, lsu_pkg::SZ_DOUBLE, 1'b0);
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        for (int x = 0; x < 2; x++) begin
          send_req(lsu_pkg::OP_LOAD, 32'hc0 + lsu_pkg::addr_t'(off), '0,
                   lsu_pkg::mem_size_e'(s), x[0]);
        end
      end
    end
    drain_responses();
    report_test("load_extend", e0);
  endtask

  task automatic test_random_stall();
    int e0;
    logic [31:0] r;
    logic [2:0] off;
    e0 = errors;
    stall_en = 1'b1;
    for (int k = 0; k < 8; k++) begin // fill the region first
      send_req(lsu_pkg::OP_STORE, RAND_BASE + lsu_pkg::addr_t'(8 * k),
               {$random(stim_seed), $random(stim_seed)}, lsu_pkg::SZ_DOUBLE, 1'b0);
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      r   = $random(stim_seed);
      off = r[6:4] & ~((3'd1 << r[1:0]) - 3'd1);
      send_req(lsu_pkg::mem_op_e'(r[2]), RAND_BASE | {26'd0, r[9:7], off},
               {$random(stim_seed), $random(stim_seed)}, lsu_pkg::mem_size_e'(r[1:0]), r[10]);
    end
    drain_responses();
    stall_en = 1'b0;
    report_test("random_stall", e0);
  endtask

  initial begin
    req_valid  = 1'b0;
    req_op     = lsu_pkg::OP_LOAD;
    req_addr   = '0;
    req_wdata  = '0;
    req_size   = lsu_pkg::SZ_BYTE;
    req_sext   = 1'b0;
    resp_ready = 1'b1;
    @(posedge rst_n);
    test_reset_state();
    test_double_rw();
    test_lane_merge();
    test_load_extend();
    test_random_stall();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- lsu_mem.f
source/lsu_pkg.sv
source/lsu_load_extend.sv
source/lsu_req_capture.sv
source/lsu_access_ctrl.sv
source/lsu_bus_sram.sv
source/lsu_mem_top.sv
bench/lsu_mem_clkgen.sv
bench/lsu_mem_props.sv
bench/lsu_mem_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = lsu_mem_tb
FLIST    = lsu_mem.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Regression failed
PASS_MSG = Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
